/* isa_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// ISA definitions for the single-cycle 16-bit load/store processor
// Opcodes, branch conditions and instruction field layouts
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package isa_pkg;

  // Data word and byte address
  typedef logic [15:0] word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [3:0]  imm4_t;
  typedef logic [7:0]  imm8_t;
  // Branch offset in words
  typedef logic [8:0]  br_off_t;

  // All sixteen opcodes, the unused ones decode as no-op
  typedef enum logic [3:0] {
    op_add = 4'h0, op_sub = 4'h1, op_xor = 4'h2, op_red    = 4'h3,
    op_sll = 4'h4, op_sra = 4'h5, op_ror = 4'h6, op_paddsb = 4'h7,
    op_lw  = 4'h8, op_sw  = 4'h9, op_llb = 4'ha, op_lhb    = 4'hb,
    op_b   = 4'hc, op_br  = 4'hd, op_pcs = 4'he, op_hlt    = 4'hf
  } opcode_e;

  // Branch conditions in bits 11..9
  typedef enum logic [2:0] {
    cond_neq    = 3'b000,  // Z clear
    cond_eq     = 3'b001,  // Z set
    cond_gt     = 3'b010,  // Z and N clear
    cond_lt     = 3'b011,  // N set
    cond_gte    = 3'b100,  // Z set or N clear
    cond_lte    = 3'b101,  // N or Z set
    cond_ovfl   = 3'b110,  // V set
    cond_always = 3'b111
  } cond_e;

  // Register format, rt doubles as the 4-bit immediate
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
  } instr_r_t;

  // Byte load format
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    imm8_t    imm8;
  } instr_i8_t;

  // Branch format
  typedef struct packed {
    opcode_e opcode;
    cond_e   cond;
    br_off_t off;
  } instr_b_t;

endpackage

`default_nettype wire

/* ctrl_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Datapath control definitions
// Control word, flag bits and ALU operation select
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package ctrl_pkg;

  // ALU function select
  typedef enum logic [2:0] {
    add    = 3'd0,
    sub    = 3'd1,
    xor_op = 3'd2,
    sll    = 3'd3,
    sra    = 3'd4,
    ror    = 3'd5,
    llb    = 3'd6,
    lhb    = 3'd7
  } alu_op_e;

  // Zero, overflow and negative flags
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // Per-flag write enables
  typedef struct packed {
    logic z_en;
    logic v_en;
    logic n_en;
  } flag_en_t;

  // Control word from decode
  typedef struct packed {
    logic     reg_write;
    logic     alu_src_imm;
    alu_op_e  alu_op;
    flag_en_t flag_en;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     branch;
    logic     halt;
    // rd is read as an operand (LLB, LHB, SW data)
    logic     rd_is_src;
  } ctrl_t;

endpackage

`default_nettype wire

/* memory1c.sv */
////////////////////////////////////////////////////////////////////////////
// Word memory with byte addressing
// Asynchronous read, write on the rising clock edge
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module memory1c #(
  parameter int addr_bits = 12
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire isa_pkg::word_t addr,
  input  wire isa_pkg::word_t data_in,
  input  wire                 enable,
  input  wire                 wr,
  output isa_pkg::word_t      data_out
);
  import isa_pkg::*;

  localparam int depth = 2 ** addr_bits;

  // Word storage
  word_t mem [depth];

  logic [addr_bits-1:0] word_idx;

  // Byte address to word index, bit 0 dropped
  assign word_idx = addr[addr_bits:1];

  // Writes blocked while reset is held so preloaded contents survive
  always_ff @(posedge clk) begin
    if (enable && wr && !reset) begin
      mem[word_idx] <= data_in;
    end
  end

  // Read returns zero when not enabled
  assign data_out = enable ? mem[word_idx] : '0;

endmodule

`default_nettype wire

/* register_file.sv */
////////////////////////////////////////////////////////////////////////////
// Register file, sixteen 16-bit registers
// Two combinational read ports, one clocked write port, r0 reads zero
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module register_file (
  input  wire                    clk,
  input  wire                    reset,
  input  wire isa_pkg::reg_idx_t src1,
  input  wire isa_pkg::reg_idx_t src2,
  input  wire isa_pkg::reg_idx_t dst,
  input  wire                    write,
  input  wire isa_pkg::word_t    dst_data,
  output isa_pkg::word_t         src1_data,
  output isa_pkg::word_t         src2_data
);
  import isa_pkg::*;

  word_t regs [16];

  // Write lands at the edge that ends the instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write && (dst != '0)) begin
      regs[dst] <= dst_data;
    end
  end

  // Register 0 is hardwired to zero
  assign src1_data = (src1 == '0) ? '0 : regs[src1];
  assign src2_data = (src2 == '0) ? '0 : regs[src2];

endmodule

`default_nettype wire

/* control_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Main decoder
// Turns the opcode into the datapath control word
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module control_unit (
  input  wire isa_pkg::word_t instr,
  output ctrl_pkg::ctrl_t     ctrl
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  instr_r_t fields;

  assign fields = instr;

  always_comb begin
    // Everything inactive unless the opcode says otherwise
    ctrl = '0;
    case (fields.opcode)
      op_add, op_sub: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = (fields.opcode == op_add) ? add : sub;
        ctrl.flag_en   = '{z_en: 1'b1, v_en: 1'b1, n_en: 1'b1};
      end
      op_xor: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_op       = xor_op;
        ctrl.flag_en.z_en = 1'b1;
      end
      // Shift amount from the 4-bit immediate
      op_sll, op_sra, op_ror: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.alu_op       = (fields.opcode == op_sll) ? sll :
                            (fields.opcode == op_sra) ? sra : ror;
        ctrl.flag_en.z_en = 1'b1;
      end
      op_lw: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
      end
      // Store data comes from rd
      op_sw: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
        ctrl.rd_is_src   = 1'b1;
      end
      op_llb, op_lhb: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = (fields.opcode == op_llb) ? llb : lhb;
        ctrl.rd_is_src = 1'b1;
      end
      op_b:    ctrl.branch = 1'b1;
      op_hlt:  ctrl.halt   = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* alu.sv */
////////////////////////////////////////////////////////////////////////////
// ALU and flag register
// Saturating add/sub, XOR, shifts, rotate, byte loads, LW/SW address
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module alu (
  input  wire                  clk,
  input  wire                  reset,
  input  wire ctrl_pkg::ctrl_t ctrl,
  input  wire isa_pkg::word_t  instr,
  input  wire isa_pkg::word_t  op1,
  input  wire isa_pkg::word_t  op2,
  output isa_pkg::word_t       result,
  output ctrl_pkg::flags_t     flags
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  instr_r_t    fields_r;
  instr_i8_t   fields_i;
  imm4_t       imm4;
  logic        is_mem;
  word_t       opnd_a;
  word_t       opnd_b;
  word_t       sum_raw;
  word_t       diff_raw;
  logic        add_ovf;
  logic        sub_ovf;
  logic        ovf;
  logic [31:0] ror_wide;
  flags_t      flags_nxt;

  assign fields_r = instr;
  assign fields_i = instr;
  assign imm4     = fields_r.rt;
  assign is_mem   = ctrl.mem_read | ctrl.mem_write;

  ////////////////////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////////////////////
  // Memory base is rs with bit 0 cleared
  assign opnd_a = is_mem ? {op1[15:1], 1'b0} : op1;
  // Memory offset is sign-extended and scaled to bytes
  // Shift amount is the zero-extended 4-bit immediate
  assign opnd_b = is_mem           ? {{11{imm4[3]}}, imm4, 1'b0} :
                  ctrl.alu_src_imm ? {12'h000, imm4} : op2;

  assign sum_raw  = opnd_a + opnd_b;
  assign diff_raw = opnd_a - opnd_b;
  // Signed overflow when the result sign disagrees with the operands
  assign add_ovf  = (opnd_a[15] == opnd_b[15]) && (sum_raw[15] != opnd_a[15]);
  assign sub_ovf  = (opnd_a[15] != opnd_b[15]) && (diff_raw[15] != opnd_a[15]);
  // Low half of the doubled word gives the rotate
  assign ror_wide = {op1, op1} >> opnd_b[3:0];

  always_comb begin
    ovf = 1'b0;
    case (ctrl.alu_op)
      // Address adds wrap, arithmetic adds saturate
      add: begin
        ovf    = add_ovf & ~is_mem;
        result = ovf ? (opnd_a[15] ? 16'h8000 : 16'h7fff) : sum_raw;
      end
      sub: begin
        ovf    = sub_ovf;
        result = ovf ? (opnd_a[15] ? 16'h8000 : 16'h7fff) : diff_raw;
      end
      xor_op:  result = op1 ^ opnd_b;
      sll:     result = op1 << opnd_b[3:0];
      sra:     result = word_t'($signed(op1) >>> opnd_b[3:0]);
      ror:     result = ror_wide[15:0];
      // Byte loads merge into the current rd value on op2
      llb:     result = {op2[15:8], fields_i.imm8};
      lhb:     result = {fields_i.imm8, op2[7:0]};
      default: result = sum_raw;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Flag register
  ////////////////////////////////////////////////////////////////////////////
  assign flags_nxt.z = (result == '0);
  assign flags_nxt.v = ovf;
  assign flags_nxt.n = result[15];

  // Each flag only moves when its enable is set
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      if (ctrl.flag_en.z_en) begin
        flags.z <= flags_nxt.z;
      end
      if (ctrl.flag_en.v_en) begin
        flags.v <= flags_nxt.v;
      end
      if (ctrl.flag_en.n_en) begin
        flags.n <= flags_nxt.n;
      end
    end
  end

endmodule

`default_nettype wire

/* pc_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Program counter
// Next-PC and branch target, condition check and halt
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module pc_unit (
  input  wire                   clk,
  input  wire                   reset,
  input  wire ctrl_pkg::ctrl_t  ctrl,
  input  wire isa_pkg::word_t   instr,
  input  wire ctrl_pkg::flags_t flags,
  output isa_pkg::word_t        pc,
  output logic                  hlt
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  instr_b_t fields;
  word_t    pc_plus2;
  word_t    pc_target;
  word_t    pc_next;
  logic     cond_met;

  assign fields    = instr;
  assign pc_plus2  = pc + 16'd2;
  // Offset counts words, relative to pc plus 2
  assign pc_target = pc_plus2 + {{6{fields.off[8]}}, fields.off, 1'b0};

  // Condition against the current flags
  always_comb begin
    case (fields.cond)
      cond_neq:    cond_met = ~flags.z;
      cond_eq:     cond_met = flags.z;
      cond_gt:     cond_met = ~flags.z & ~flags.n;
      cond_lt:     cond_met = flags.n;
      cond_gte:    cond_met = flags.z | ~flags.n;
      cond_lte:    cond_met = flags.n | flags.z;
      cond_ovfl:   cond_met = flags.v;
      default:     cond_met = 1'b1;
    endcase
  end

  // HLT freezes the pc
  assign pc_next = ctrl.halt                ? pc        :
                   (ctrl.branch && cond_met) ? pc_target : pc_plus2;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  assign hlt = ctrl.halt;

endmodule

`default_nettype wire

/* cpu.sv */
////////////////////////////////////////////////////////////////////////////
// Single-cycle 16-bit load/store processor
// Fetch, decode, execute, memory and write-back in one clock
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module cpu #(
  parameter int addr_bits = 12
) (
  input  wire            clk,
  input  wire            reset,
  output logic           hlt,
  output isa_pkg::word_t pc
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  word_t    instr;
  instr_r_t fields;
  ctrl_t    ctrl;
  flags_t   flags;
  reg_idx_t src2_idx;
  word_t    src1_data;
  word_t    src2_data;
  word_t    alu_result;
  word_t    dmem_data;
  word_t    wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch and decode
  ////////////////////////////////////////////////////////////////////////////
  // Read-only instruction memory
  memory1c #(.addr_bits(addr_bits)) imem (
    .clk(clk), .reset(reset), .addr(pc), .data_in('0),
    .enable(1'b1), .wr(1'b0), .data_out(instr)
  );

  pc_unit pc_unit0 (
    .clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr),
    .flags(flags), .pc(pc), .hlt(hlt)
  );

  control_unit control_unit0 (.instr(instr), .ctrl(ctrl));

  assign fields   = instr;
  // Second read port takes rd for stores and byte loads
  assign src2_idx = ctrl.rd_is_src ? fields.rd : fields.rt;

  register_file register_file0 (
    .clk(clk), .reset(reset), .src1(fields.rs), .src2(src2_idx),
    .dst(fields.rd), .write(ctrl.reg_write), .dst_data(wb_data),
    .src1_data(src1_data), .src2_data(src2_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute, memory and write-back
  ////////////////////////////////////////////////////////////////////////////
  alu alu0 (
    .clk(clk), .reset(reset), .ctrl(ctrl), .instr(instr),
    .op1(src1_data), .op2(src2_data), .result(alu_result), .flags(flags)
  );

  // ALU result is the byte address for LW and SW
  memory1c #(.addr_bits(addr_bits)) dmem (
    .clk(clk), .reset(reset), .addr(alu_result), .data_in(src2_data),
    .enable(ctrl.mem_read | ctrl.mem_write), .wr(ctrl.mem_write),
    .data_out(dmem_data)
  );

  assign wb_data = ctrl.mem_to_reg ? dmem_data : alu_result;

endmodule

`default_nettype wire

/* cpu_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the single-cycle 16-bit processor
// Loads directed programs, predicts the pc trace from the ISA, checks it
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module cpu_tb;
  import isa_pkg::*;

  localparam int    addr_bits = 12;
  // RED is not implemented, decodes as no-op
  localparam word_t nop_word  = 16'h3000;
  localparam word_t hlt_word  = 16'hf000;

  logic   clk;
  logic   reset;
  logic   hlt;
  word_t  pc;
  integer seed;

  // Program image and predicted pc trace
  word_t prog [$];
  word_t exp_pc [$];

  cpu #(.addr_bits(addr_bits)) dut0 (.clk(clk), .reset(reset), .hlt(hlt), .pc(pc));

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Encoding and ISA reference
  ////////////////////////////////////////////////////////////////////////////
  function automatic word_t enc_r(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic word_t enc_i(opcode_e op, reg_idx_t rd, imm8_t imm);
    return {op, rd, imm};
  endfunction

  function automatic word_t enc_b(cond_e c, br_off_t off);
    return {op_b, c, off};
  endfunction

  // Background data, depends on the whole word index
  function automatic word_t fill_word(int idx);
    return word_t'(idx) ^ 16'hc3a5;
  endfunction

  function automatic word_t ror16(word_t x, int s);
    return (x >> s) | (x << (16 - s));
  endfunction

  // Signed add/sub clamped to the 16-bit range
  function automatic word_t sat_addsub(word_t a, word_t b, logic do_sub, output logic ovf);
    int full;
    full = do_sub ? int'($signed(a)) - int'($signed(b)) : int'($signed(a)) + int'($signed(b));
    ovf  = (full > 32767) || (full < -32768);
    if (full > 32767) return 16'h7fff;
    if (full < -32768) return 16'h8000;
    return word_t'(full);
  endfunction

  function automatic logic cond_true(cond_e c, logic z, logic v, logic n);
    case (c)
      cond_neq:  return !z;
      cond_eq:   return z;
      cond_gt:   return !z && !n;
      cond_lt:   return n;
      cond_gte:  return z || !n;
      cond_lte:  return n || z;
      cond_ovfl: return v;
      default:   return 1'b1;
    endcase
  endfunction

  // Walk the program at ISA level, one pc per instruction
  task automatic predict_trace();
    word_t    regs [16];
    word_t    dm [int];
    logic     z, v, n, ovf, wr;
    word_t    mpc, ins, a, b, d, r, ea;
    instr_r_t f;
    instr_b_t fb;
    int       off;
    z = 1'b0;
    v = 1'b0;
    n = 1'b0;
    foreach (regs[i]) regs[i] = '0;
    exp_pc.delete();
    mpc = '0;
    for (int step = 0; step < 200; step++) begin
      exp_pc.push_back(mpc);
      ins = prog[mpc[15:1]];
      f   = ins;
      fb  = ins;
      if (f.opcode == op_hlt) break;
      a   = regs[f.rs];
      b   = regs[f.rt];
      d   = regs[f.rd];
      off = $signed(f.rt);
      ea  = (a & 16'hfffe) + word_t'(2 * off);
      r   = '0;
      wr  = 1'b1;
      mpc = mpc + 16'd2;
      case (f.opcode)
        op_add, op_sub: begin
          r = sat_addsub(a, b, f.opcode == op_sub, ovf);
          z = (r == '0);
          v = ovf;
          n = r[15];
        end
        op_xor: r = a ^ b;
        op_sll: r = a << f.rt;
        op_sra: r = word_t'($signed(a) >>> f.rt);
        op_ror: r = ror16(a, f.rt);
        op_lw: begin
          off = ea[addr_bits:1];
          r   = dm.exists(off) ? dm[off] : fill_word(off);
        end
        op_sw: begin
          dm[int'(ea[addr_bits:1])] = d;
          wr = 1'b0;
        end
        op_llb: r = {d[15:8], ins[7:0]};
        op_lhb: r = {ins[7:0], d[7:0]};
        op_b: begin
          wr = 1'b0;
          if (cond_true(fb.cond, z, v, n)) begin
            off = $signed(fb.off);
            mpc = mpc + word_t'(2 * off);
          end
        end
        default: wr = 1'b0;
      endcase
      // Logic and shifts touch Z only
      if (f.opcode inside {op_xor, op_sll, op_sra, op_ror}) z = (r == '0);
      if (wr && f.rd != '0) regs[f.rd] = r;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program building and run control
  ////////////////////////////////////////////////////////////////////////////
  task automatic load_const(input reg_idx_t r, input word_t v);
    prog.push_back(enc_i(op_llb, r, v[7:0]));
    prog.push_back(enc_i(op_lhb, r, v[15:8]));
  endtask

  // Taken branch skips the no-op
  task automatic branch_probe(input cond_e c);
    prog.push_back(enc_b(c, 9'd1));
    prog.push_back(nop_word);
  endtask

  task automatic probe_flags();
    branch_probe(cond_eq);
    branch_probe(cond_lt);
    branch_probe(cond_gt);
    branch_probe(cond_ovfl);
  endtask

  task automatic compare_regs(input reg_idx_t ra, input reg_idx_t rb);
    prog.push_back(enc_r(op_sub, 15, ra, rb));
    branch_probe(cond_eq);
  endtask

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic run_program(input string name);
    int    cyc;
    logic  done;
    logic  exp_h;
    word_t hold_pc;
    predict_trace();
    @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    // Memories loaded while the write ports are blocked by reset
    for (int i = 0; i < prog.size(); i++) dut0.imem.mem[i] = prog[i];
    for (int i = 0; i < 2 ** addr_bits; i++) dut0.dmem.mem[i] = fill_word(i);
    repeat (9) @(posedge clk);
    reset <= 1'b0;
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      exp_h = (cyc == exp_pc.size() - 1);
      assert (pc === exp_pc[cyc]) else begin
        $display("[ERROR] %s cycle %0d pc: expected %h, got %h", name, cyc, exp_pc[cyc], pc);
        abort_run();
      end
      assert (hlt === exp_h) else begin
        $display("[ERROR] %s cycle %0d hlt: expected %h, got %h", name, cyc, exp_h, hlt);
        abort_run();
      end
      done = hlt;
      cyc++;
      if (!done && cyc >= 200) begin
        $display("Timeout: %s did not halt within 200 cycles", name);
        abort_run();
      end
    end
    // Halted core must hold its pc
    hold_pc = pc;
    repeat (5) begin
      @(negedge clk);
      assert (pc === hold_pc && hlt === 1'b1) else begin
        $display("[ERROR] %s halt hold pc: expected %h, got %h, hlt %h", name, hold_pc, pc, hlt);
        abort_run();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic reset_halt_test();
    prog.delete();
    prog.push_back(hlt_word);
    run_program("reset_halt");
  endtask

  task automatic arith_flags_test();
    word_t a, b;
    a = word_t'($random(seed));
    b = word_t'($random(seed));
    prog.delete();
    load_const(1, a);
    load_const(2, b);
    prog.push_back(enc_r(op_add, 3, 1, 2));
    probe_flags();
    prog.push_back(enc_r(op_sub, 4, 1, 2));
    probe_flags();
    prog.push_back(enc_r(op_sub, 5, 1, 1));
    probe_flags();
    // Positive then negative saturation
    load_const(6, 16'h7000 | (a & 16'h0fff));
    load_const(7, 16'h4000 | (b & 16'h3fff));
    prog.push_back(enc_r(op_add, 8, 6, 7));
    probe_flags();
    load_const(9, 16'h8000 | (b & 16'h0fff));
    prog.push_back(enc_r(op_sub, 10, 9, 6));
    probe_flags();
    prog.push_back(hlt_word);
    run_program("arith_flags");
  endtask

  task automatic logic_shift_test();
    word_t x, y;
    int    s;
    x = word_t'($random(seed));
    y = word_t'($random(seed));
    s = {$random(seed)} % 16;
    prog.delete();
    load_const(1, x);
    load_const(2, y);
    prog.push_back(enc_r(op_xor, 3, 1, 2));
    load_const(4, x ^ y);
    compare_regs(3, 4);
    // Set V, then logic and shifts must leave it alone
    load_const(5, 16'h7fff);
    prog.push_back(enc_r(op_add, 6, 5, 5));
    // Z is clear here, XOR of equal values sets it
    prog.push_back(enc_r(op_xor, 13, 1, 1));
    branch_probe(cond_eq);
    // Rotate of a nonzero value clears Z again
    prog.push_back(enc_r(op_ror, 14, 5, reg_idx_t'(s)));
    branch_probe(cond_eq);
    prog.push_back(enc_r(op_sll, 7, 1, reg_idx_t'(s)));
    branch_probe(cond_ovfl);
    load_const(8, x << s);
    compare_regs(7, 8);
    prog.push_back(enc_r(op_sra, 9, 1, reg_idx_t'(s)));
    load_const(10, word_t'($signed(x) >>> s));
    compare_regs(9, 10);
    prog.push_back(enc_r(op_ror, 11, 1, reg_idx_t'(s)));
    load_const(12, ror16(x, s));
    compare_regs(11, 12);
    prog.push_back(hlt_word);
    run_program("logic_shift");
  endtask

  task automatic memory_test();
    word_t base, a, b;
    base = 16'h0400 + (word_t'($random(seed)) & 16'h03fe);
    a    = word_t'($random(seed));
    b    = word_t'($random(seed));
    prog.delete();
    load_const(1, base);
    load_const(2, a);
    load_const(3, b);
    load_const(8, base | 16'h0001);
    prog.push_back(enc_r(op_sw, 2, 1, 4'h3));
    prog.push_back(enc_r(op_sw, 3, 1, 4'hc));
    prog.push_back(enc_r(op_lw, 4, 1, 4'h3));
    prog.push_back(enc_r(op_lw, 5, 1, 4'hc));
    compare_regs(4, 2);
    compare_regs(5, 3);
    // Odd base has bit 0 dropped
    prog.push_back(enc_r(op_lw, 9, 8, 4'h3));
    compare_regs(9, 2);
    prog.push_back(enc_r(op_lw, 10, 1, 4'h7));
    compare_regs(10, 2);
    prog.push_back(hlt_word);
    run_program("memory");
  endtask

  task automatic branch_loop_test();
    int count;
    count = 3 + ({$random(seed)} % 8);
    prog.delete();
    prog.push_back(enc_i(op_llb, 1, imm8_t'(count)));
    prog.push_back(enc_i(op_llb, 2, 8'd1));
    prog.push_back(enc_r(op_sub, 1, 1, 2));
    prog.push_back(enc_b(cond_eq, 9'd1));
    // Back to the SUB at address 4
    prog.push_back(enc_b(cond_always, 9'h1fd));
    prog.push_back(hlt_word);
    run_program("branch_loop");
    assert (exp_pc.size() == 3 * count + 2) else begin
      $display("Loop of %0d passes produced a trace of %0d entries", count, exp_pc.size());
      abort_run();
    end
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    seed  = 32'h2c22;
    reset_halt_test();
    arith_flags_test();
    logic_shift_test();
    memory_test();
    branch_loop_test();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
isa_pkg.sv
ctrl_pkg.sv
memory1c.sv
register_file.sv
control_unit.sv
alu.sv
pc_unit.sv
cpu.sv
cpu_tb.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - isa_pkg.sv
  - ctrl_pkg.sv
  - memory1c.sv
  - register_file.sv
  - control_unit.sv
  - alu.sv
  - pc_unit.sv
  - cpu.sv
  - target: test
    files:
      - cpu_tb.sv
